//--- src/uart_pkg.sv
package uart_pkg;

    // Wishbone bus geometry.
    localparam int unsigned ADDR_W = 32;
    localparam int unsigned DATA_W = 32;
    localparam int unsigned SEL_W  = 4;

    typedef logic [7:0]        byte_t;
    typedef logic [DATA_W-1:0] word_t;

    // Register offsets, OR'ed onto the base address of the slave.
    localparam logic [ADDR_W-1:0] DIV_OFS = 32'h0000_0000;
    localparam logic [ADDR_W-1:0] DAT_OFS = 32'h0000_0004;
    localparam logic [ADDR_W-1:0] CFG_OFS = 32'h0000_0008;

    // Divider after reset, in clock cycles per bit.
    localparam word_t DIV_RESET = 32'd16;

    // Below this divider the receiver can no longer find the bit centre.
    localparam word_t DIV_MIN = 32'd4;

    // Idle bit times sent after reset and after a divider change.
    localparam int unsigned GUARD_BITS = 15;

    // Value of a DATA read while no received byte is buffered.
    localparam word_t RX_EMPTY = '1;

endpackage

//--- src/uart_core_if.sv
interface uart_core_if;

    // Effective bit period in clock cycles, never below the minimum divider.
    uart_pkg::word_t divider;
    logic            enabled;
    logic            div_changed;

    // Transmit path.
    uart_pkg::byte_t tx_data;
    logic            tx_start;
    logic            tx_busy;

    // Receive path.
    uart_pkg::byte_t rx_data;
    logic            rx_valid;
    logic            rx_clear;

    modport regs (
        output divider, enabled, div_changed, tx_data, tx_start, rx_clear,
        input  tx_busy, rx_data, rx_valid
    );

    // The transmitter needs enabled to decide whether a divider change earns a guard time.
    modport tx (
        input  divider, enabled, div_changed, tx_data, tx_start,
        output tx_busy
    );

    modport rx (
        input  divider, enabled, rx_clear,
        output rx_data, rx_valid
    );

endinterface

//--- src/uart_regs_wb.sv
module uart_regs_wb #(
    parameter logic [uart_pkg::ADDR_W-1:0] BASE_ADR = 32'h2000_0000
) (
    input  logic                       clk,
    input  logic                       resetn,
    input  uart_pkg::word_t            wb_adr_i,
    input  uart_pkg::word_t            wb_dat_i,
    input  logic [uart_pkg::SEL_W-1:0] wb_sel_i,
    input  logic                       wb_we_i,
    input  logic                       wb_cyc_i,
    input  logic                       wb_stb_i,
    output logic                       wb_ack_o,
    output uart_pkg::word_t            wb_dat_o,
    output logic                       uart_enabled_o,
    uart_core_if.regs                  core
);

    // The slave answers every address in a 16-byte window above BASE_ADR.
    localparam int unsigned WIN_LSB = 4;

    logic            req;
    logic            win_hit;
    logic            div_hit;
    logic            cfg_hit;
    logic            dat_hit;
    logic            dat_wr;
    logic            take;
    uart_pkg::word_t rd_word;

    logic            ack_q;
    logic            enabled_q;
    logic            tx_start_q;
    logic            rx_clear_q;
    logic            div_changed_q;
    uart_pkg::word_t div_q;
    uart_pkg::word_t dat_q;
    uart_pkg::byte_t tx_data_q;

    // A request already acknowledged is not seen again in the ack cycle.
    assign req = wb_cyc_i && wb_stb_i && !ack_q;

    assign win_hit = req && (wb_adr_i[uart_pkg::ADDR_W-1:WIN_LSB] ==
                             BASE_ADR[uart_pkg::ADDR_W-1:WIN_LSB]);
    assign div_hit = req && (wb_adr_i == (BASE_ADR | uart_pkg::DIV_OFS));
    assign cfg_hit = req && (wb_adr_i == (BASE_ADR | uart_pkg::CFG_OFS));
    assign dat_hit = req && (wb_adr_i == (BASE_ADR | uart_pkg::DAT_OFS));
    assign dat_wr  = dat_hit && wb_we_i && wb_sel_i[0];

    // A DATA write waits here while the transmitter is still busy.
    assign take = win_hit && !(dat_wr && core.tx_busy);

    always_comb begin
        rd_word = '0;
        if (div_hit) begin
            rd_word = div_q;
        end else if (cfg_hit) begin
            rd_word = {{(uart_pkg::DATA_W-1){1'b0}}, enabled_q};
        end else if (dat_hit) begin
            rd_word = core.rx_valid ? uart_pkg::word_t'(core.rx_data) : uart_pkg::RX_EMPTY;
        end
    end

    always_ff @(posedge clk) begin
        if (!resetn) begin
            ack_q         <= 1'b0;
            enabled_q     <= 1'b0;
            tx_start_q    <= 1'b0;
            rx_clear_q    <= 1'b0;
            div_changed_q <= 1'b0;
            div_q         <= uart_pkg::DIV_RESET;
        end else begin
            ack_q         <= take;
            tx_start_q    <= take && dat_wr;
            rx_clear_q    <= take && dat_hit && !wb_we_i;
            div_changed_q <= take && div_hit && wb_we_i;
            if (take && div_hit && wb_we_i) begin
                for (int i = 0; i < uart_pkg::SEL_W; i++) begin
                    if (wb_sel_i[i]) begin
                        div_q[8*i +: 8] <= wb_dat_i[8*i +: 8];
                    end
                end
            end
            if (take && cfg_hit && wb_we_i && wb_sel_i[0]) begin
                enabled_q <= wb_dat_i[0];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (take && !wb_we_i) begin
            dat_q <= rd_word;
        end
        if (take && dat_wr) begin
            tx_data_q <= wb_dat_i[7:0];
        end
    end

    assign wb_ack_o       = ack_q;
    assign wb_dat_o       = dat_q;
    assign uart_enabled_o = enabled_q;

    // DIV reads back as written, but the serial logic never runs faster than DIV_MIN.
    assign core.divider     = (div_q < uart_pkg::DIV_MIN) ? uart_pkg::DIV_MIN : div_q;
    assign core.enabled     = enabled_q;
    assign core.div_changed = div_changed_q;
    assign core.tx_data     = tx_data_q;
    assign core.tx_start    = tx_start_q;
    assign core.rx_clear    = rx_clear_q;

endmodule

//--- src/uart_tx.sv
module uart_tx (
    input  logic       clk,
    input  logic       resetn,
    uart_core_if.tx    core,
    output logic       ser_tx_o
);

    localparam int unsigned BIT_CNT_W  = $clog2(uart_pkg::GUARD_BITS + 1);
    localparam int unsigned FRAME_BITS = 10;

    logic [9:0]           shift_q;
    logic [BIT_CNT_W-1:0] bits_q;
    uart_pkg::word_t      div_cnt_q;
    logic                 guard_req_q;
    logic                 guard_now;
    logic                 bit_end;

    assign guard_now = core.div_changed && core.enabled;
    assign bit_end   = (div_cnt_q == core.divider - 1);

    // Bits still to go on the line, start to stop or a run of guard bits.
    always_ff @(posedge clk) begin
        if (!resetn) begin
            shift_q     <= '1;
            bits_q      <= BIT_CNT_W'(uart_pkg::GUARD_BITS);
            div_cnt_q   <= '0;
            guard_req_q <= 1'b0;
        end else if (bits_q == '0) begin
            div_cnt_q <= '0;
            if (guard_req_q || guard_now) begin
                shift_q     <= '1;
                bits_q      <= BIT_CNT_W'(uart_pkg::GUARD_BITS);
                guard_req_q <= 1'b0;
            end else if (core.tx_start) begin
                shift_q <= {1'b1, core.tx_data, 1'b0};
                bits_q  <= BIT_CNT_W'(FRAME_BITS);
            end
        end else begin
            // A divider change during a frame is kept and served once the line is idle.
            if (guard_now) begin
                guard_req_q <= 1'b1;
            end
            if (bit_end) begin
                shift_q   <= {1'b1, shift_q[9:1]};
                bits_q    <= bits_q - 1'b1;
                div_cnt_q <= '0;
            end else begin
                div_cnt_q <= div_cnt_q + 1'b1;
            end
        end
    end

    assign ser_tx_o     = shift_q[0];
    assign core.tx_busy = (bits_q != '0) || guard_req_q;

endmodule

//--- src/uart_rx.sv
module uart_rx (
    input  logic       clk,
    input  logic       resetn,
    uart_core_if.rx    core,
    input  logic       ser_rx_i
);

    // State 0 is idle, 1 waits for the start-bit centre, 2 to 9 take the data bits.
    localparam logic [3:0] ST_IDLE  = 4'd0;
    localparam logic [3:0] ST_START = 4'd1;
    localparam logic [3:0] ST_STOP  = 4'd10;

    logic [1:0]      rx_sync_q;
    logic            rx_line;
    logic [3:0]      state_q;
    uart_pkg::word_t div_cnt_q;
    uart_pkg::byte_t shift_q;
    uart_pkg::byte_t data_q;
    logic            valid_q;
    logic            half_end;
    logic            bit_end;

    assign rx_line  = rx_sync_q[1];
    assign half_end = (div_cnt_q == (core.divider >> 1) - 1);
    assign bit_end  = (div_cnt_q == core.divider - 1);

    always_ff @(posedge clk) begin
        if (!resetn) begin
            rx_sync_q <= '1;
            state_q   <= ST_IDLE;
            div_cnt_q <= '0;
            valid_q   <= 1'b0;
        end else begin
            rx_sync_q <= {rx_sync_q[0], ser_rx_i};
            if (core.rx_clear) begin
                valid_q <= 1'b0;
            end
            if (state_q == ST_IDLE) begin
                div_cnt_q <= '0;
                if (core.enabled && !rx_line) begin
                    state_q <= ST_START;
                end
            end else if (state_q == ST_START) begin
                if (half_end) begin
                    div_cnt_q <= '0;
                    // A glitch that is gone by the centre is not a start bit.
                    state_q   <= rx_line ? ST_IDLE : state_q + 1'b1;
                end else begin
                    div_cnt_q <= div_cnt_q + 1'b1;
                end
            end else if (bit_end) begin
                div_cnt_q <= '0;
                if (state_q == ST_STOP) begin
                    state_q <= ST_IDLE;
                    if (core.enabled) begin
                        valid_q <= 1'b1;
                    end
                end else begin
                    state_q <= state_q + 1'b1;
                end
            end else begin
                div_cnt_q <= div_cnt_q + 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (bit_end && state_q > ST_START && state_q < ST_STOP) begin
            shift_q <= {rx_line, shift_q[7:1]};
        end
        if (bit_end && state_q == ST_STOP && core.enabled) begin
            data_q <= shift_q;
        end
    end

    assign core.rx_data  = data_q;
    assign core.rx_valid = valid_q;

endmodule

//--- src/wb_uart_top.sv
module wb_uart_top #(
    parameter logic [uart_pkg::ADDR_W-1:0] BASE_ADR = 32'h2000_0000
) (
    input  logic                        clk,
    input  logic                        resetn,
    input  logic [uart_pkg::ADDR_W-1:0] wb_adr_i,
    input  logic [uart_pkg::DATA_W-1:0] wb_dat_i,
    input  logic [uart_pkg::SEL_W-1:0]  wb_sel_i,
    input  logic                        wb_we_i,
    input  logic                        wb_cyc_i,
    input  logic                        wb_stb_i,
    output logic                        wb_ack_o,
    output logic [uart_pkg::DATA_W-1:0] wb_dat_o,
    input  logic                        ser_rx_i,
    output logic                        ser_tx_o,
    output logic                        uart_enabled_o
);

    uart_core_if core_if ();

    uart_regs_wb #(
        .BASE_ADR (BASE_ADR)
    ) i_regs (
        .clk            (clk),
        .resetn         (resetn),
        .wb_adr_i       (wb_adr_i),
        .wb_dat_i       (wb_dat_i),
        .wb_sel_i       (wb_sel_i),
        .wb_we_i        (wb_we_i),
        .wb_cyc_i       (wb_cyc_i),
        .wb_stb_i       (wb_stb_i),
        .wb_ack_o       (wb_ack_o),
        .wb_dat_o       (wb_dat_o),
        .uart_enabled_o (uart_enabled_o),
        .core           (core_if.regs)
    );

    uart_tx i_tx (
        .clk      (clk),
        .resetn   (resetn),
        .core     (core_if.tx),
        .ser_tx_o (ser_tx_o)
    );

    uart_rx i_rx (
        .clk      (clk),
        .resetn   (resetn),
        .core     (core_if.rx),
        .ser_rx_i (ser_rx_i)
    );

endmodule

//--- tb/wb_uart_sva.sv
module wb_uart_sva (
    input logic clk,
    input logic resetn,
    input logic wb_cyc_i,
    input logic wb_stb_i,
    input logic wb_ack_o,
    input logic tx_start,
    input logic tx_busy
);

    // An ack always answers a request that is still on the bus.
    ack_needs_req: assert property (@(posedge clk) disable iff (!resetn)
        wb_ack_o |-> (wb_cyc_i && wb_stb_i))
        else $error("wb_ack_o high without an active request");

    ack_one_cycle: assert property (@(posedge clk) disable iff (!resetn)
        wb_ack_o |=> !wb_ack_o)
        else $error("wb_ack_o held for more than one cycle");

    // The transmitter only takes a new byte when it is idle.
    start_when_idle: assert property (@(posedge clk) disable iff (!resetn)
        !(tx_start && tx_busy))
        else $error("tx_start pulsed while tx_busy was high");

    ack_low_after_reset: assert property (@(posedge clk)
        !resetn |=> !wb_ack_o)
        else $error("wb_ack_o high in the cycle after reset");

endmodule

bind uart_regs_wb wb_uart_sva i_sva (
    .clk      (clk),
    .resetn   (resetn),
    .wb_cyc_i (wb_cyc_i),
    .wb_stb_i (wb_stb_i),
    .wb_ack_o (wb_ack_o),
    .tx_start (core.tx_start),
    .tx_busy  (core.tx_busy)
);

//--- tb/tb_wb_uart.sv
module tb_wb_uart;

    localparam uart_pkg::word_t BASE = 32'h2000_0000;
    localparam int D_RUN = 8;
    // Frames on the serial lines over the whole run, both directions.
    localparam int FRAMES = 7;
    localparam longint unsigned WATCHDOG_T =
        (uart_pkg::GUARD_BITS + 10 * FRAMES) * uart_pkg::DIV_RESET * 10 * 2;

    logic                       clk;
    logic                       resetn;
    uart_pkg::word_t            wb_adr_i;
    uart_pkg::word_t            wb_dat_i;
    logic [uart_pkg::SEL_W-1:0] wb_sel_i;
    logic                       wb_we_i;
    logic                       wb_cyc_i;
    logic                       wb_stb_i;
    logic                       wb_ack_o;
    uart_pkg::word_t            wb_dat_o;
    logic                       ser_rx_i;
    logic                       ser_tx_o;
    logic                       uart_enabled_o;

    int unsigned     pass_cnt;
    int unsigned     fail_cnt;
    time             last_ack_t;
    uart_pkg::word_t exp_frames[$];
    uart_pkg::word_t act_frames[$];
    string           frame_names[$];

    wb_uart_top i_dut (
        .clk            (clk),
        .resetn         (resetn),
        .wb_adr_i       (wb_adr_i),
        .wb_dat_i       (wb_dat_i),
        .wb_sel_i       (wb_sel_i),
        .wb_we_i        (wb_we_i),
        .wb_cyc_i       (wb_cyc_i),
        .wb_stb_i       (wb_stb_i),
        .wb_ack_o       (wb_ack_o),
        .wb_dat_o       (wb_dat_o),
        .ser_rx_i       (ser_rx_i),
        .ser_tx_o       (ser_tx_o),
        .uart_enabled_o (uart_enabled_o)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // Expected 8N1 frame: start bit in bit 0, data LSB first, stop bit in bit 9.
    function automatic uart_pkg::word_t frame_of(uart_pkg::byte_t b);
        return uart_pkg::word_t'({1'b1, b, 1'b0});
    endfunction

    function automatic uart_pkg::word_t div_after(uart_pkg::word_t old_div,
                                                  uart_pkg::word_t data,
                                                  logic [uart_pkg::SEL_W-1:0] sel);
        uart_pkg::word_t res;
        res = old_div;
        for (int i = 0; i < uart_pkg::SEL_W; i++) begin
            if (sel[i]) begin
                res[8*i +: 8] = data[8*i +: 8];
            end
        end
        return res;
    endfunction

    task automatic note_pass(input string name);
        $display("   pass  %s", name);
        pass_cnt++;
    endtask

    task automatic note_failure(input string what);
        $display("%s", what);
        fail_cnt++;
    endtask

    task automatic check_word(input string name, input uart_pkg::word_t exp,
                              input uart_pkg::word_t act);
        if (exp !== act) begin
            $display("** Error %s: expected 0x%08h, actual 0x%08h", name, exp, act);
            fail_cnt++;
        end else begin
            note_pass(name);
        end
    endtask

    task automatic check_byte(input string name, input uart_pkg::byte_t exp,
                              input uart_pkg::byte_t act);
        if (exp !== act) begin
            $display("** Error %s: expected 0x%02h, actual 0x%02h", name, exp, act);
            fail_cnt++;
        end else begin
            note_pass(name);
        end
    endtask

    task automatic wb_write(input uart_pkg::word_t adr, input uart_pkg::word_t data,
                            input logic [uart_pkg::SEL_W-1:0] sel);
        @(posedge clk);
        wb_adr_i <= adr;
        wb_dat_i <= data;
        wb_sel_i <= sel;
        wb_we_i  <= 1'b1;
        wb_cyc_i <= 1'b1;
        wb_stb_i <= 1'b1;
        do @(negedge clk); while (!wb_ack_o);
        last_ack_t = $time;
        @(posedge clk);
        wb_cyc_i <= 1'b0;
        wb_stb_i <= 1'b0;
        wb_we_i  <= 1'b0;
    endtask

    task automatic wb_read(input uart_pkg::word_t adr, output uart_pkg::word_t data);
        @(posedge clk);
        wb_adr_i <= adr;
        wb_sel_i <= '1;
        wb_we_i  <= 1'b0;
        wb_cyc_i <= 1'b1;
        wb_stb_i <= 1'b1;
        do @(negedge clk); while (!wb_ack_o);
        data = wb_dat_o;
        @(posedge clk);
        wb_cyc_i <= 1'b0;
        wb_stb_i <= 1'b0;
    endtask

    task automatic send_serial(input uart_pkg::byte_t b, input int d);
        logic [9:0] bits;
        bits = 10'(frame_of(b));
        for (int i = 0; i < 10; i++) begin
            @(posedge clk);
            ser_rx_i <= bits[i];
            repeat (d - 1) @(posedge clk);
        end
        // One idle bit time so the receiver has taken the stop-bit sample.
        repeat (d) @(posedge clk);
    endtask

    // Samples at negative edges, half a cycle past the bit centres.
    task automatic sample_serial(input int d, output time t_start);
        uart_pkg::word_t frame;
        int              waited;
        logic            seen;
        frame   = '0;
        waited  = 0;
        seen    = 1'b0;
        t_start = 0;
        while (!seen && waited < 12 * d) begin
            @(negedge clk);
            seen = (ser_tx_o == 1'b0);
            waited++;
        end
        if (!seen) begin
            note_failure($sformatf("No start bit seen on ser_tx_o within %0d cycles", 12 * d));
            void'(exp_frames.pop_front());
            void'(frame_names.pop_front());
            return;
        end
        t_start = $time;
        repeat (d / 2) @(negedge clk);
        frame[0] = ser_tx_o;
        for (int i = 1; i < 10; i++) begin
            repeat (d) @(negedge clk);
            frame[i] = ser_tx_o;
        end
        act_frames.push_back(frame);
    endtask

    // Pairs every sampled frame with the oldest expected one.
    initial begin
        forever begin
            @(negedge clk);
            while (act_frames.size() > 0 && exp_frames.size() > 0) begin
                check_word(frame_names.pop_front(), exp_frames.pop_front(),
                           act_frames.pop_front());
            end
        end
    end

    initial begin
        #(WATCHDOG_T);
        $display("Watchdog expired after %0d time units, the run did not finish", WATCHDOG_T);
        $display("Checks failed");
        $finish;
    end

    initial begin
        uart_pkg::word_t            rd;
        uart_pkg::word_t            div_model;
        uart_pkg::word_t            wdata;
        uart_pkg::byte_t            b;
        logic [uart_pkg::SEL_W-1:0] sel;
        time                        t_first;
        time                        t_second;
        void'($urandom(96));
        pass_cnt = 0;
        fail_cnt = 0;
        resetn   = 1'b0;
        wb_adr_i = '0;
        wb_dat_i = '0;
        wb_sel_i = '0;
        wb_we_i  = 1'b0;
        wb_cyc_i = 1'b0;
        wb_stb_i = 1'b0;
        ser_rx_i = 1'b1;
        repeat (2) @(posedge clk);
        resetn <= 1'b1;

        wb_read(BASE | uart_pkg::DIV_OFS, rd);
        check_word("reset DIV", uart_pkg::DIV_RESET, rd);
        wb_read(BASE | uart_pkg::CFG_OFS, rd);
        check_word("reset CFG", '0, rd);
        wb_read(BASE | uart_pkg::DAT_OFS, rd);
        check_word("reset DATA", uart_pkg::RX_EMPTY, rd);
        @(negedge clk);
        check_word("reset ser_tx_o", 32'd1, uart_pkg::word_t'(ser_tx_o));
        check_word("reset uart_enabled_o", '0, uart_pkg::word_t'(uart_enabled_o));

        // The guard after reset runs at DIV_RESET and must end before DIV changes.
        repeat (uart_pkg::GUARD_BITS * uart_pkg::DIV_RESET) @(posedge clk);
        div_model = uart_pkg::DIV_RESET;
        for (int i = 0; i < 5; i++) begin
            wdata = (i == 4) ? uart_pkg::word_t'(D_RUN) : $urandom();
            sel   = (i == 4) ? 4'hf : 4'($urandom());
            div_model = div_after(div_model, wdata, sel);
            wb_write(BASE | uart_pkg::DIV_OFS, wdata, sel);
            wb_read(BASE | uart_pkg::DIV_OFS, rd);
            check_word($sformatf("DIV lane write %0d", i), div_model, rd);
        end

        wb_write(BASE | uart_pkg::CFG_OFS, 32'h1, 4'h1);
        wb_read(BASE | uart_pkg::CFG_OFS, rd);
        check_word("CFG enable", 32'h1, rd);
        check_word("uart_enabled_o after enable", 32'h1, uart_pkg::word_t'(uart_enabled_o));
        for (int i = 0; i < 3; i++) begin
            b = uart_pkg::byte_t'($urandom());
            exp_frames.push_back(frame_of(b));
            frame_names.push_back($sformatf("tx frame %0d", i));
            fork
                wb_write(BASE | uart_pkg::DAT_OFS, uart_pkg::word_t'(b), 4'h1);
                sample_serial(D_RUN, t_first);
            join
        end

        for (int i = 0; i < 2; i++) begin
            frame_names.push_back($sformatf("back-pressure frame %0d", i));
        end
        fork
            begin
                b = uart_pkg::byte_t'($urandom());
                exp_frames.push_back(frame_of(b));
                wb_write(BASE | uart_pkg::DAT_OFS, uart_pkg::word_t'(b), 4'h1);
                b = uart_pkg::byte_t'($urandom());
                exp_frames.push_back(frame_of(b));
                wb_write(BASE | uart_pkg::DAT_OFS, uart_pkg::word_t'(b), 4'h1);
            end
            begin
                sample_serial(D_RUN, t_first);
                sample_serial(D_RUN, t_second);
            end
        join
        // The second ack may only come once the first frame has sent its stop bit.
        if (last_ack_t < t_first + time'(100 * D_RUN)) begin
            note_failure("Second DATA write was acknowledged before the first frame ended");
        end else begin
            note_pass("back-pressure ack timing");
        end
        // The second frame starts only after the first frame is complete.
        if (t_second < t_first + time'(100 * D_RUN)) begin
            note_failure("Second back-pressure frame started before the first frame ended");
        end else begin
            note_pass("back-pressure frame spacing");
        end

        b = uart_pkg::byte_t'($urandom());
        send_serial(b, D_RUN);
        wb_read(BASE | uart_pkg::DAT_OFS, rd);
        check_byte("rx byte", b, rd[7:0]);
        check_word("rx upper bits", '0, rd >> 8);
        wb_read(BASE | uart_pkg::DAT_OFS, rd);
        check_word("rx empty after read", uart_pkg::RX_EMPTY, rd);

        wb_write(BASE | uart_pkg::CFG_OFS, 32'h0, 4'h1);
        check_word("uart_enabled_o after disable", '0, uart_pkg::word_t'(uart_enabled_o));
        send_serial(uart_pkg::byte_t'($urandom()), D_RUN);
        wb_read(BASE | uart_pkg::DAT_OFS, rd);
        check_word("rx ignored while disabled", uart_pkg::RX_EMPTY, rd);

        repeat (2) @(negedge clk);
        if (exp_frames.size() != 0) begin
            note_failure("Some expected frames never appeared on ser_tx_o");
        end
        $display("Checks: %0d passed, %0d failed", pass_cnt, fail_cnt);
        if (fail_cnt == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

endmodule

//--- wb_uart.f
src/uart_pkg.sv
src/uart_core_if.sv
src/uart_regs_wb.sv
src/uart_tx.sv
src/uart_rx.sv
src/wb_uart_top.sv
tb/wb_uart_sva.sv
tb/tb_wb_uart.sv

//--- Makefile
# Verilator build for the wb_uart project.
VERILATOR ?= verilator
TOP       ?= tb_wb_uart
SIM_SEED  ?= 96
LOG       ?= sim.log
FLIST     ?= wb_uart.f
BUILD_DIR ?= obj_dir

SRCS  := $(shell grep -v '^+' $(FLIST))
VFLAGS := --timing --assert --top-module $(TOP) -f $(FLIST)

.PHONY: run lint clean

run: $(BUILD_DIR)/V$(TOP)
	./$(BUILD_DIR)/V$(TOP) +verilator+seed+$(SIM_SEED) 2>&1 | tee $(LOG)
	@if grep -q "Checks failed" $(LOG); then \
		echo "Simulation failed, see $(LOG)"; exit 1; \
	elif ! grep -q "All checks passed" $(LOG); then \
		echo "Simulation ended without a result, see $(LOG)"; exit 1; \
	fi

$(BUILD_DIR)/V$(TOP): $(SRCS) $(FLIST)
	$(VERILATOR) --binary -j 0 $(VFLAGS) --Mdir $(BUILD_DIR)

lint:
	$(VERILATOR) --lint-only $(VFLAGS)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
